// ==== source/blk_cache_config.svh ====
// Sizing constants for the direct-mapped block cache
`ifndef BLK_CACHE_CONFIG_SVH
`define BLK_CACHE_CONFIG_SVH

// ----------------------------------------
// Block geometry
// ----------------------------------------

// Words held in the single cached block
// 128 words of 4 bytes cover a 512 byte window
`define CACHE_WORDS 128

// ----------------------------------------
// Bus widths
// ----------------------------------------

// Byte address width on both the CPU and memory side
`define CACHE_ADDR_W 32

// Data word width, one word per burst beat
`define CACHE_DATA_W 32

`endif

// ==== source/blk_cache_pkg.sv ====
// Shared vector types and FSM encoding for the block cache
`include "blk_cache_config.svh"

package blk_cache_pkg;

    // ----------------------------------------
    // Derived widths
    // ----------------------------------------
    localparam int BLK_WORDS = `CACHE_WORDS;
    localparam int ADDR_W    = `CACHE_ADDR_W;
    localparam int DATA_W    = `CACHE_DATA_W;
    localparam int STRB_W    = DATA_W / 8;
    // Byte offset inside a word, then word index inside the block
    localparam int OFFSET_W  = $clog2(STRB_W);
    localparam int INDEX_W   = $clog2(BLK_WORDS);
    // Whatever is left above the block window is the tag
    localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;
    // AXI-style length field
    localparam int LEN_W     = 8;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [STRB_W-1:0]  strb_t;
    // Word index, also the burst set pointer
    typedef logic [INDEX_W-1:0] set_idx_t;
    typedef logic [TAG_W-1:0]   block_tag_t;
    // Beats minus one
    typedef logic [LEN_W-1:0]   burst_len_t;

    // Refill engine states
    typedef enum logic [2:0] {
        IDLE,
        SEND_WRITE_REQ,
        SEND_WRITE_DATA,
        WAIT_WRITE_RESP,
        SEND_READ_REQ,
        RECEIVE_READ_DATA
    } cache_state_t;

endpackage

// ==== source/cache_line_store.sv ====
// Data array of the cached block with CPU byte writes, burst fill and two read ports
module cache_line_store (
    input  logic                    aclk,
    // CPU side
    input  logic                    cpu_we,
    input  blk_cache_pkg::set_idx_t cpu_idx,
    input  blk_cache_pkg::word_t    cpu_wdata,
    input  blk_cache_pkg::strb_t    cpu_strb,
    output blk_cache_pkg::word_t    cpu_rdata,
    // Refill side
    input  logic                    fill_en,
    input  blk_cache_pkg::set_idx_t fill_idx,
    input  blk_cache_pkg::word_t    fill_data,
    // Write-back side
    input  blk_cache_pkg::set_idx_t wb_idx,
    output blk_cache_pkg::word_t    wb_data
);
    import blk_cache_pkg::*;

    // One word per set, no reset on the storage
    word_t mem [BLK_WORDS];

    // Bit mask built from the byte enables
    word_t byte_mask;

    // ----------------------------------------
    // Byte enable expansion
    // ----------------------------------------
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            byte_mask[8*b +: 8] = {8{cpu_strb[b]}};
        end
    end

    // ----------------------------------------
    // Single write process
    // ----------------------------------------
    // Fill and CPU writes never overlap, the controller
    // only lets CPU writes through while the engine is idle
    always_ff @(posedge aclk) begin
        if (fill_en) begin
            // Refill beats land as whole words
            mem[fill_idx] <= fill_data;
        end else if (cpu_we) begin
            // Keep the disabled bytes, take the enabled ones
            mem[cpu_idx] <= (mem[cpu_idx] & ~byte_mask) | (cpu_wdata & byte_mask);
        end
    end

    // ----------------------------------------
    // Asynchronous read ports
    // ----------------------------------------
    // CPU read hit returns in the same cycle
    assign cpu_rdata = mem[cpu_idx];
    // Write-back data follows the engine set pointer
    assign wb_data   = mem[wb_idx];

endmodule

// ==== source/cache_tag_ctrl.sv ====
// Tag, valid and dirty state of the block with hit detection, CPU stall and miss request
module cache_tag_ctrl (
    input  logic                      aclk,
    input  logic                      rst_n,
    // CPU request
    input  blk_cache_pkg::addr_t      address,
    input  logic                      read_enable,
    input  logic                      write_enable,
    input  blk_cache_pkg::strb_t      byte_enable,
    // Engine status
    input  logic                      engine_busy,
    input  logic                      fill_done,
    // CPU stall and line store control
    output logic                      cache_stall,
    output logic                      cpu_we,
    output blk_cache_pkg::set_idx_t   cpu_idx,
    // Miss request to the engine
    output logic                      miss_req,
    output logic                      need_writeback,
    output blk_cache_pkg::block_tag_t victim_tag,
    output blk_cache_pkg::block_tag_t req_tag
);
    import blk_cache_pkg::*;

    // Block bookkeeping
    block_tag_t block_tag;
    logic       block_valid;
    logic       block_dirty;

    // Request decode
    logic       wr_active;
    logic       req_active;
    logic       hit;

    // ----------------------------------------
    // Address split
    // ----------------------------------------
    // | tag | index | byte offset |
    assign req_tag = address[ADDR_W-1 -: TAG_W];
    assign cpu_idx = address[OFFSET_W +: INDEX_W];

    // ----------------------------------------
    // Hit and stall decode
    // ----------------------------------------
    // A write with no byte enabled is no request at all
    assign wr_active  = write_enable & (|byte_enable);
    assign req_active = read_enable | wr_active;

    assign hit = block_valid && (block_tag == req_tag);

    // Miss stays high until the fill makes the request hit
    assign miss_req   = req_active & ~hit;

    // Stall on a pending miss or any engine activity
    assign cache_stall = miss_req | engine_busy;

    // Only write hits with the engine idle reach the array
    assign cpu_we = wr_active & hit & ~engine_busy;

    // Engine needs the old block for write-back
    assign need_writeback = block_dirty;
    assign victim_tag     = block_tag;

    // ----------------------------------------
    // Block state registers
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            block_tag   <= '0;
            block_valid <= 1'b0;
            block_dirty <= 1'b0;
        end else begin
            if (fill_done) begin
                // Freshly loaded block matches memory
                block_tag   <= req_tag;
                block_valid <= 1'b1;
                block_dirty <= 1'b0;
            end else if (cpu_we) begin
                // Write hit commits together with the array
                block_dirty <= 1'b1;
            end
        end
    end

endmodule

// ==== source/cache_refill_engine.sv ====
// Burst FSM that writes back a dirty block and refills the block from main memory
module cache_refill_engine (
    input  logic                      aclk,
    input  logic                      rst_n,
    // Miss request from the tag controller
    input  logic                      miss_req,
    input  logic                      need_writeback,
    input  blk_cache_pkg::block_tag_t victim_tag,
    input  blk_cache_pkg::block_tag_t req_tag,
    output logic                      engine_busy,
    output logic                      fill_done,
    // Line store ports
    output logic                      fill_en,
    output blk_cache_pkg::set_idx_t   fill_idx,
    output blk_cache_pkg::word_t      fill_data,
    output blk_cache_pkg::set_idx_t   wb_idx,
    input  blk_cache_pkg::word_t      wb_data,
    // Write address channel
    output logic                      awvalid,
    input  logic                      awready,
    output blk_cache_pkg::addr_t      awaddr,
    output blk_cache_pkg::burst_len_t awlen,
    // Write data channel
    output logic                      wvalid,
    input  logic                      wready,
    output blk_cache_pkg::word_t      wdata,
    output logic                      wlast,
    // Write response channel
    input  logic                      bvalid,
    output logic                      bready,
    // Read address channel
    output logic                      arvalid,
    input  logic                      arready,
    output blk_cache_pkg::addr_t      araddr,
    output blk_cache_pkg::burst_len_t arlen,
    // Read data channel
    input  logic                      rvalid,
    output logic                      rready,
    input  blk_cache_pkg::word_t      rdata,
    input  logic                      rlast
);
    import blk_cache_pkg::*;

    // Last word index of the block
    localparam set_idx_t LAST_IDX = set_idx_t'(BLK_WORDS - 1);

    cache_state_t state;
    cache_state_t next_state;

    // Beat counter shared by write-back and refill
    set_idx_t set_ptr;
    set_idx_t next_set_ptr;

    // Accepted beats
    logic w_beat;
    logic r_beat;

    // ----------------------------------------
    // Fixed burst fields
    // ----------------------------------------
    // Whole block on every burst
    assign awlen = burst_len_t'(BLK_WORDS - 1);
    assign arlen = burst_len_t'(BLK_WORDS - 1);

    // Bursts start at the block base, tag then zeros
    // Both tags stay put while the engine works
    assign awaddr = {victim_tag, {(INDEX_W + OFFSET_W){1'b0}}};
    assign araddr = {req_tag, {(INDEX_W + OFFSET_W){1'b0}}};

    // ----------------------------------------
    // Handshake outputs, decoded from state
    // ----------------------------------------
    assign awvalid = (state == SEND_WRITE_REQ);
    assign wvalid  = (state == SEND_WRITE_DATA);
    assign bready  = (state == WAIT_WRITE_RESP);
    assign arvalid = (state == SEND_READ_REQ);
    assign rready  = (state == RECEIVE_READ_DATA);

    assign w_beat = wvalid & wready;
    assign r_beat = rvalid & rready;

    // Write-back data streams straight from the array
    assign wb_idx = set_ptr;
    assign wdata  = wb_data;
    assign wlast  = wvalid && (set_ptr == LAST_IDX);

    // Refill beats go straight into the array
    assign fill_en   = r_beat;
    assign fill_idx  = set_ptr;
    assign fill_data = rdata;
    // Pulse on the last accepted read beat
    assign fill_done = r_beat & rlast;

    assign engine_busy = (state != IDLE);

    // ----------------------------------------
    // Next state and pointer
    // ----------------------------------------
    always_comb begin
        next_state   = state;
        next_set_ptr = set_ptr;

        case (state)
            IDLE: begin
                // Every burst starts from word zero
                next_set_ptr = '0;
                if (miss_req) begin
                    // Dirty block goes back to memory first
                    if (need_writeback) begin
                        next_state = SEND_WRITE_REQ;
                    end else begin
                        next_state = SEND_READ_REQ;
                    end
                end
            end
            SEND_WRITE_REQ: begin
                if (awready) begin
                    next_state = SEND_WRITE_DATA;
                end
            end
            SEND_WRITE_DATA: begin
                // Pointer moves only on accepted beats
                if (w_beat) begin
                    next_set_ptr = set_ptr + 1'b1;
                    if (wlast) begin
                        next_state = WAIT_WRITE_RESP;
                    end
                end
            end
            WAIT_WRITE_RESP: begin
                // Response code is not checked
                if (bvalid) begin
                    next_state = SEND_READ_REQ;
                end
            end
            SEND_READ_REQ: begin
                if (arready) begin
                    next_state = RECEIVE_READ_DATA;
                end
            end
            RECEIVE_READ_DATA: begin
                if (r_beat) begin
                    next_set_ptr = set_ptr + 1'b1;
                    if (rlast) begin
                        next_state = IDLE;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state   <= IDLE;
            set_ptr <= '0;
        end else begin
            state   <= next_state;
            set_ptr <= next_set_ptr;
        end
    end

endmodule

// ==== source/blk_cache_top.sv ====
// Direct-mapped block cache with a CPU word port and a burst memory master port
module blk_cache_top (
    input  logic                      aclk,
    input  logic                      rst_n,
    // CPU port
    input  blk_cache_pkg::addr_t      address,
    input  blk_cache_pkg::word_t      write_data,
    input  logic                      read_enable,
    input  logic                      write_enable,
    input  blk_cache_pkg::strb_t      byte_enable,
    output blk_cache_pkg::word_t      read_data,
    output logic                      cache_stall,
    // Write address channel
    output logic                      awvalid,
    input  logic                      awready,
    output blk_cache_pkg::addr_t      awaddr,
    output blk_cache_pkg::burst_len_t awlen,
    // Write data channel
    output logic                      wvalid,
    input  logic                      wready,
    output blk_cache_pkg::word_t      wdata,
    output logic                      wlast,
    // Write response channel
    input  logic                      bvalid,
    output logic                      bready,
    // Read address channel
    output logic                      arvalid,
    input  logic                      arready,
    output blk_cache_pkg::addr_t      araddr,
    output blk_cache_pkg::burst_len_t arlen,
    // Read data channel
    input  logic                      rvalid,
    output logic                      rready,
    input  blk_cache_pkg::word_t      rdata,
    input  logic                      rlast
);
    import blk_cache_pkg::*;

    // Controller to line store
    logic       cpu_we;
    set_idx_t   cpu_idx;

    // Controller and engine handshake
    logic       miss_req;
    logic       need_writeback;
    block_tag_t victim_tag;
    block_tag_t req_tag;
    logic       engine_busy;
    logic       fill_done;

    // Engine to line store
    logic       fill_en;
    set_idx_t   fill_idx;
    word_t      fill_data;
    set_idx_t   wb_idx;
    word_t      wb_data;

    // ----------------------------------------
    // Hit, miss and stall decisions
    // ----------------------------------------
    cache_tag_ctrl u_tag_ctrl (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .address        (address),
        .read_enable    (read_enable),
        .write_enable   (write_enable),
        .byte_enable    (byte_enable),
        .engine_busy    (engine_busy),
        .fill_done      (fill_done),
        .cache_stall    (cache_stall),
        .cpu_we         (cpu_we),
        .cpu_idx        (cpu_idx),
        .miss_req       (miss_req),
        .need_writeback (need_writeback),
        .victim_tag     (victim_tag),
        .req_tag        (req_tag)
    );

    // ----------------------------------------
    // Block data
    // ----------------------------------------
    cache_line_store u_line_store (
        .aclk      (aclk),
        .cpu_we    (cpu_we),
        .cpu_idx   (cpu_idx),
        .cpu_wdata (write_data),
        .cpu_strb  (byte_enable),
        .cpu_rdata (read_data),
        .fill_en   (fill_en),
        .fill_idx  (fill_idx),
        .fill_data (fill_data),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data)
    );

    // ----------------------------------------
    // Memory bursts
    // ----------------------------------------
    cache_refill_engine u_refill_engine (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .miss_req       (miss_req),
        .need_writeback (need_writeback),
        .victim_tag     (victim_tag),
        .req_tag        (req_tag),
        .engine_busy    (engine_busy),
        .fill_done      (fill_done),
        .fill_en        (fill_en),
        .fill_idx       (fill_idx),
        .fill_data      (fill_data),
        .wb_idx         (wb_idx),
        .wb_data        (wb_data),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wlast          (wlast),
        .bvalid         (bvalid),
        .bready         (bready),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arlen          (arlen),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rlast          (rlast)
    );

endmodule

// ==== testbench/blk_cache_props.sv ====
// Concurrent checks on the CPU stall and the burst master handshakes
module blk_cache_props (
    input logic                        aclk,
    input logic                        rst_n,
    input logic                        cache_stall,
    input blk_cache_pkg::cache_state_t state,
    input logic                        awvalid,
    input logic                        awready,
    input blk_cache_pkg::addr_t        awaddr,
    input logic                        wvalid,
    input logic                        wready,
    input blk_cache_pkg::word_t        wdata,
    input logic                        wlast,
    input logic                        arvalid,
    input logic                        arready,
    input blk_cache_pkg::addr_t        araddr
);
    timeunit 1ns;
    timeprecision 100ps;
    import blk_cache_pkg::*;

    // Accepted write beats since the last write address
    int w_beats;

    always_ff @(posedge aclk) begin
        if (!rst_n || (awvalid && awready)) begin
            w_beats <= 0;
        end else if (wvalid && wready) begin
            w_beats <= w_beats + 1;
        end
    end

    // ----------------------------------------
    // Master payload holds while waiting
    // ----------------------------------------
    aw_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("write address changed before it was accepted");

    w_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("write data changed before it was accepted");

    ar_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("read address changed before it was accepted");

    // Last beat is the 128th, and only that one
    wlast_pos: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && wready |-> (wlast == (w_beats == BLK_WORDS - 1)))
        else $error("wlast on the wrong write beat");

    // Held request hits once the engine is back in IDLE
    stall_end: assert property (@(posedge aclk) disable iff (!rst_n)
        $past(state) != IDLE && state == IDLE |-> !cache_stall)
        else $error("cache_stall still high after the refill");

endmodule

bind blk_cache_top blk_cache_props u_props (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .cache_stall (cache_stall),
    .state       (u_refill_engine.state),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .wlast       (wlast),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr)
);

// ==== testbench/tb_burst_memory.sv ====
// Behavioral burst memory slave with pattern contents and random handshake gaps
`include "blk_cache_config.svh"

module tb_burst_memory (
    input  logic                 aclk,
    input  logic                 stall_en,
    input  logic                 awvalid,
    output logic                 awready,
    input  blk_cache_pkg::addr_t awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  blk_cache_pkg::word_t wdata,
    input  logic                 wlast,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic                 arvalid,
    output logic                 arready,
    input  blk_cache_pkg::addr_t araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output blk_cache_pkg::word_t rdata,
    output logic                 rlast
);
    timeunit 1ns;
    timeprecision 100ps;
    import blk_cache_pkg::*;

    // 16 KB window, word index is address bits 13 to 2
    localparam int MEM_WORDS = 4096;

    word_t       mem [MEM_WORDS];
    int          seed = 32'h3bf7;
    int          aw_count;
    logic [11:0] wbase;
    logic [11:0] rbase;
    int          wcnt;
    int          rcnt;
    logic        bpend;
    logic        rbusy;
    logic        r_hold;
    // Gap enable as seen at the last edge
    logic        gap_en;

    // Ready or valid this cycle, three in four under stalls
    function automatic logic go();
        if (!gap_en) begin
            return 1'b1;
        end
        return ($random(seed) & 3) != 0;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i << 2) ^ 32'hC0DE0000;
        end
        {awready, wready, bvalid, arready, rvalid, rlast} = '0;
        rdata    = '0;
        aw_count = 0;
        {wbase, rbase, wcnt, rcnt, bpend, rbusy} = '0;
    end

    always @(posedge aclk) begin
        // Transfers seen with the values just before the edge
        gap_en = stall_en;
        r_hold = rvalid && !rready;
        if (awvalid && awready) begin
            wbase = awaddr[13:2];
            wcnt  = 0;
            aw_count++;
        end
        if (wvalid && wready) begin
            mem[wbase + 12'(wcnt)] = wdata;
            wcnt++;
            if (wlast) begin
                bpend = 1'b1;
            end
        end
        if (bvalid && bready) begin
            bpend = 1'b0;
        end
        if (arvalid && arready) begin
            rbase = araddr[13:2];
            rcnt  = 0;
            rbusy = 1'b1;
        end
        if (rvalid && rready) begin
            rcnt++;
            if (rlast) begin
                rbusy = 1'b0;
            end
        end
        #5;
        awready = go();
        wready  = go();
        arready = go();
        // Slave valids stay up until taken
        bvalid  = bpend && (bvalid || go());
        if (!r_hold) begin
            rvalid = rbusy && go();
            rdata  = mem[rbase + 12'(rcnt)];
            rlast  = (rcnt == `CACHE_WORDS - 1);
        end
    end

endmodule

// ==== testbench/tb_blk_cache.sv ====
// Testbench for the block cache with directed tests against a burst memory model
`include "blk_cache_config.svh"

module tb_blk_cache;
    timeunit 1ns;
    timeprecision 100ps;
    import blk_cache_pkg::*;

    localparam int WORDS      = `CACHE_WORDS;
    localparam int WAIT_LIMIT = 5000;

    logic       aclk;
    logic       rst_n;
    addr_t      address;
    word_t      write_data;
    logic       read_enable;
    logic       write_enable;
    strb_t      byte_enable;
    word_t      read_data;
    logic       cache_stall;
    logic       stall_en;
    // Memory port
    logic       awvalid;
    logic       awready;
    logic       wvalid;
    logic       wready;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    logic       arvalid;
    logic       arready;
    logic       rvalid;
    logic       rready;
    logic       rlast;
    addr_t      awaddr;
    addr_t      araddr;
    burst_len_t awlen;
    burst_len_t arlen;
    word_t      wdata;
    word_t      rdata;

    int         seed = 32'h3bf7;
    // Last merged word, kept for the write-back test
    addr_t      merged_addr;
    word_t      merged_word;
    // Base of the block the cache holds, the next victim
    addr_t      loaded_base;

    blk_cache_top dut (.*);

    tb_burst_memory u_mem (.*);

    initial begin
        aclk = 1'b0;
    end

    always #50 aclk = ~aclk;

    // ----------------------------------------
    // Reference values
    // ----------------------------------------
    function automatic word_t pattern(addr_t a);
        return a ^ 32'hC0DE0000;
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    // Block address is the tag with the word and byte bits cleared
    function automatic addr_t block_base(addr_t a);
        return a & ~addr_t'(WORDS * 4 - 1);
    endfunction

    function automatic word_t mem_word(addr_t a);
        return u_mem.mem[a[13:2]];
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_len(string name, burst_len_t got, burst_len_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_stall(logic exp);
        if (cache_stall !== exp) begin
            fail_now($sformatf("FAILED cache_stall: got %h, expected %h", cache_stall, exp));
        end
    endtask

    // Entered 1 ns after the drive point, leaves at the same phase
    task automatic wait_stall_low(string what);
        int n;
        n = 0;
        while (cache_stall) begin
            @(posedge aclk);
            #6;
            n++;
            if (n > WAIT_LIMIT) begin
                fail_now($sformatf("Timed out waiting for the stall to end on %s", what));
            end
        end
    endtask

    // ----------------------------------------
    // Burst address and length monitor
    // ----------------------------------------
    // Falling edge, halfway between the drive points
    always @(negedge aclk) begin
        if (rst_n && awvalid) begin
            check_addr("awaddr", awaddr, loaded_base);
            check_len("awlen", awlen, burst_len_t'(WORDS - 1));
        end
        if (rst_n && arvalid) begin
            check_addr("araddr", araddr, block_base(address));
            check_len("arlen", arlen, burst_len_t'(WORDS - 1));
        end
    end

    // ----------------------------------------
    // CPU port drivers
    // ----------------------------------------
    task automatic cpu_read(addr_t a, logic exp_stall, output word_t data);
        address     = a;
        read_enable = 1'b1;
        #1;
        check_stall(exp_stall);
        wait_stall_low($sformatf("read of %h", a));
        data = read_data;
        // Block now held by the cache
        loaded_base = block_base(a);
        @(posedge aclk);
        #5;
        read_enable = 1'b0;
    endtask

    task automatic cpu_write(addr_t a, word_t d, strb_t strb, logic exp_stall);
        address      = a;
        write_data   = d;
        byte_enable  = strb;
        write_enable = 1'b1;
        #1;
        check_stall(exp_stall);
        wait_stall_low($sformatf("write of %h", a));
        @(posedge aclk);
        #5;
        write_enable = 1'b0;
        byte_enable  = '0;
    endtask

    task automatic read_check(addr_t a, logic exp_stall, word_t exp);
        word_t got;
        cpu_read(a, exp_stall, got);
        check_word($sformatf("read_data at %h", a), got, exp);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_first_miss(addr_t a);
        check_stall(1'b0);
        read_check(a, 1'b1, pattern(a));
    endtask

    task automatic test_hits(addr_t base);
        addr_t a;
        for (int i = 0; i < WORDS; i++) begin
            a = base + addr_t'(4 * i);
            read_check(a, 1'b0, pattern(a));
        end
        // A few random indices out of order
        for (int i = 0; i < 8; i++) begin
            a = base + addr_t'(4 * ($random(seed) & (WORDS - 1)));
            read_check(a, 1'b0, pattern(a));
        end
    endtask

    task automatic test_byte_writes(addr_t a);
        word_t exp;
        exp = merge_bytes(pattern(a), 32'hAABBCCDD, 4'b0101);
        cpu_write(a, 32'hAABBCCDD, 4'b0101, 1'b0);
        exp = merge_bytes(exp, 32'h11223344, 4'b1000);
        cpu_write(a, 32'h11223344, 4'b1000, 1'b0);
        read_check(a, 1'b0, exp);
        // No byte enabled, no request even on a missing block
        cpu_write(a + addr_t'(WORDS * 4), 32'hFFFFFFFF, 4'b0000, 1'b0);
        read_check(a, 1'b0, exp);
        merged_addr = a;
        merged_word = exp;
    endtask

    task automatic test_writeback(addr_t old_base, addr_t new_base);
        int aw_before;
        read_check(new_base + 4, 1'b1, pattern(new_base + 4));
        check_word("memory write-back word", mem_word(merged_addr), merged_word);
        check_word("memory block base word", mem_word(old_base), pattern(old_base));
        // Clean block now, so the way back is a read burst only
        aw_before = u_mem.aw_count;
        read_check(merged_addr, 1'b1, merged_word);
        if (u_mem.aw_count != aw_before) begin
            fail_now("A write burst was issued on a clean miss");
        end
        check_word("memory clean block word", mem_word(new_base + 4), pattern(new_base + 4));
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        rst_n        = 1'b0;
        address      = '0;
        write_data   = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        byte_enable  = '0;
        stall_en     = 1'b0;
        loaded_base  = '0;
        repeat (16) @(posedge aclk);
        #5;
        rst_n = 1'b1;
        @(posedge aclk);
        #5;

        test_first_miss(32'h0000_1000);
        test_hits(32'h0000_1000);
        test_byte_writes(32'h0000_1040);
        test_writeback(32'h0000_1000, 32'h0000_1200);

        // Same again with gaps on every handshake
        stall_en = 1'b1;
        test_first_miss(32'h0000_2000);
        test_hits(32'h0000_2000);
        test_byte_writes(32'h0000_2080);
        test_writeback(32'h0000_2000, 32'h0000_2200);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+source
source/blk_cache_pkg.sv
source/cache_line_store.sv
source/cache_tag_ctrl.sv
source/cache_refill_engine.sv
source/blk_cache_top.sv
testbench/blk_cache_props.sv
testbench/tb_burst_memory.sv
testbench/tb_blk_cache.sv

// ==== Makefile ====
# Verilator build for the block cache testbench

VERILATOR ?= verilator
TOP       ?= tb_blk_cache
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BIN): $(FLIST) $(wildcard source/*.sv source/*.svh testbench/*.sv)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
